//--- verilog/slice_data_pkg.sv
`default_nettype none

package slice_data_pkg;

    // ADC code and delay chain.
    localparam int n_adc = 8;
    localparam int n_chain = (2 ** n_adc) - 1;  // One flop per LSB step.

    // First adder stage reduces groups of chain bits to partial counts.
    localparam int n_group = 16;
    localparam int n_partial = 16;
    localparam int n_part_w = $clog2(n_group + 1);  // Counts 0..16 need 5 bits.

    // Registers from the input pins to adder_out.
    localparam int pipe_depth = 3;

endpackage

`default_nettype wire

//--- verilog/slice_ctl_pkg.sv
`default_nettype none

package slice_ctl_pkg;

    // Binary trim and delay control codes.
    localparam int n_ctl = 5;

    // Thermometer form seen by the unit cells.
    localparam int n_thm = (2 ** n_ctl) - 1;

endpackage

`default_nettype wire

//--- verilog/bin2thm.sv
`timescale 1ns/1ps
`default_nettype none

module bin2thm
    import slice_ctl_pkg::*;
#(
    parameter int Nbit = n_ctl
) (
    input  logic [Nbit-1:0]          bin,
    output logic [(2 ** Nbit)-2:0]   thm
);

    localparam int Nthm = (2 ** Nbit) - 1;

    // Bit i turns on once the code exceeds i, so cells switch in monotonically.
    always_comb begin
        for (int i = 0; i < Nthm; i++) begin
            thm[i] = (i < int'(bin));
        end
    end

endmodule

`default_nettype wire

//--- verilog/tdc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_capture
    import slice_data_pkg::*;
(
    input  logic               clk_adder,
    input  logic               rstb,
    input  logic [n_chain-1:0] ff_out,
    input  logic               sign,
    input  logic               en_tdc_phase_reverse,
    output logic [n_chain-1:0] chain_q,
    output logic               sign_q,
    output logic               clk_tdc_phase_reverse
);

    logic en_rev_meta;  // First synchronizer flop.

    // The enable comes from a slow control domain.
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            en_rev_meta <= 1'b0;
            clk_tdc_phase_reverse <= 1'b0;
        end else begin
            en_rev_meta <= en_tdc_phase_reverse;
            clk_tdc_phase_reverse <= en_rev_meta;
        end
    end

    // A reversed chain latches inverted levels, so flip them back here.
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            chain_q <= '0;
            sign_q <= 1'b0;
        end else begin
            chain_q <= clk_tdc_phase_reverse ? ~ff_out : ff_out;
            sign_q <= sign;
        end
    end

endmodule

`default_nettype wire

//--- verilog/wallace_adder.sv
`timescale 1ns/1ps
`default_nettype none

module wallace_adder
    import slice_data_pkg::*;
(
    input  logic               clk_adder,
    input  logic               rstb,
    input  logic [n_chain-1:0] d_in,
    input  logic               sign_in,
    output logic [n_adc-1:0]   d_out,
    output logic               sign_out
);

    logic [n_group*n_partial-1:0] d_pad;      // Chain padded to whole groups.
    logic [n_part_w-1:0]          part_q [n_partial];
    logic                         sign_d;
    logic [n_adc-1:0]             csa_a;
    logic [n_adc-1:0]             csa_b;

    function automatic logic [1:0] fa(input logic a, input logic b, input logic c);
        return {(a & b) | (a & c) | (b & c), a ^ b ^ c};  // {carry, sum}.
    endfunction

    function automatic logic [1:0] ha(input logic a, input logic b);
        return {a & b, a ^ b};
    endfunction

    // Column compression of 16 bits into a 5-bit count.
    function automatic logic [n_part_w-1:0] count16(input logic [n_group-1:0] b);
        logic [4:0]          s1;
        logic [4:0]          c1;
        logic [1:0]          s2;
        logic [1:0]          c2;
        logic [1:0]          t;
        logic [1:0]          u;
        logic                c3;
        logic                v;
        logic                w;
        logic                x;
        logic                y;
        logic                z;
        logic                z2;
        logic [n_part_w-1:0] cnt;
        int                  i;
        // Weight 1 column.
        for (i = 0; i < 5; i++) begin
            {c1[i], s1[i]} = fa(b[3*i], b[3*i+1], b[3*i+2]);
        end
        {c2[0], s2[0]} = fa(s1[0], s1[1], s1[2]);
        {c2[1], s2[1]} = fa(s1[3], s1[4], b[15]);
        {c3, cnt[0]} = ha(s2[0], s2[1]);
        // Weight 2 column.
        {u[0], t[0]} = fa(c1[0], c1[1], c1[2]);
        {u[1], t[1]} = fa(c1[3], c1[4], c2[0]);
        {w, v} = fa(t[0], t[1], c2[1]);
        {x, cnt[1]} = ha(v, c3);
        // Weight 4 and 8 columns.
        {z, y} = fa(u[0], u[1], w);
        {z2, cnt[2]} = ha(y, x);
        {cnt[4], cnt[3]} = ha(z, z2);
        return cnt;
    endfunction

    assign d_pad = {1'b0, d_in};  // Last group holds 15 real bits.

    // Stage 1 registers the partial count of each group.
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            for (int g = 0; g < n_partial; g++) begin
                part_q[g] <= '0;
            end
            sign_d <= 1'b0;
        end else begin
            for (int g = 0; g < n_partial; g++) begin
                part_q[g] <= count16(d_pad[g*n_group +: n_group]);
            end
            sign_d <= sign_in;
        end
    end

    // 3:2 carry-save reduction of the partial counts down to two operands.
    always_comb begin : csa_tree
        logic [n_adc-1:0] lvl [n_partial];
        logic [n_adc-1:0] nxt [n_partial];
        int               n;
        int               m;
        int               i;
        for (i = 0; i < n_partial; i++) begin
            lvl[i] = {{(n_adc-n_part_w){1'b0}}, part_q[i]};
        end
        for (n = n_partial; n > 2; n = m) begin
            for (i = 0; i < n_partial; i++) begin
                nxt[i] = '0;
            end
            m = 0;
            for (i = 0; i + 2 < n; i += 3) begin
                nxt[m] = lvl[i] ^ lvl[i+1] ^ lvl[i+2];
                nxt[m+1] = ((lvl[i] & lvl[i+1]) | (lvl[i] & lvl[i+2])
                           | (lvl[i+1] & lvl[i+2])) << 1;
                m += 2;
            end
            for (i = 3 * (n / 3); i < n; i++) begin
                nxt[m] = lvl[i];  // Leftover rows pass to the next level.
                m += 1;
            end
            lvl = nxt;
        end
        csa_a = lvl[0];
        csa_b = lvl[1];
    end

    // Stage 2 does the final carry-propagate add. Sum is at most 255.
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            d_out <= '0;
            sign_out <= 1'b0;
        end else begin
            d_out <= csa_a + csa_b;
            sign_out <= sign_d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/stochastic_adc_backend.sv
`timescale 1ns/1ps
`default_nettype none

module stochastic_adc_backend
    import slice_data_pkg::*;
    import slice_ctl_pkg::*;
(
    input  logic               clk_adder,
    input  logic               rstb,
    input  logic [n_chain-1:0] ff_out,
    input  logic               sign,
    input  logic               en_tdc_phase_reverse,
    input  logic [n_ctl-1:0]   ctl_v2t_p,
    input  logic [n_ctl-1:0]   ctl_v2t_n,
    input  logic [n_ctl-1:0]   ctl_dcdl,
    output logic [n_adc-1:0]   adder_out,
    output logic               sign_out,
    output logic               clk_tdc_phase_reverse,
    output logic [n_thm-1:0]   thm_ctl_v2t_p,
    output logic [n_thm-1:0]   thm_ctl_v2t_n,
    output logic [n_thm-1:0]   thm_ctl_dcdl
);

    logic [n_chain-1:0] chain_q;
    logic               sign_q;

    // V2T trim for the positive and negative side.
    bin2thm #(
        .Nbit(n_ctl)
    ) ib2tp (
        .bin(ctl_v2t_p),
        .thm(thm_ctl_v2t_p)
    );

    bin2thm #(
        .Nbit(n_ctl)
    ) ib2tn (
        .bin(ctl_v2t_n),
        .thm(thm_ctl_v2t_n)
    );

    // Coarse delay ahead of the TDC chain.
    bin2thm #(
        .Nbit(n_ctl)
    ) ib2t_tdc (
        .bin(ctl_dcdl),
        .thm(thm_ctl_dcdl)
    );

    tdc_capture icapture (
        .clk_adder(clk_adder),
        .rstb(rstb),
        .ff_out(ff_out),
        .sign(sign),
        .en_tdc_phase_reverse(en_tdc_phase_reverse),
        .chain_q(chain_q),
        .sign_q(sign_q),
        .clk_tdc_phase_reverse(clk_tdc_phase_reverse)  // Back to the delay chain.
    );

    wallace_adder iadder (
        .clk_adder(clk_adder),
        .rstb(rstb),
        .d_in(chain_q),
        .sign_in(sign_q),
        .d_out(adder_out),
        .sign_out(sign_out)
    );

endmodule

`default_nettype wire

//--- verification/stochastic_adc_backend_checker.sv
`timescale 1ns/1ps
`default_nettype none

module stochastic_adc_backend_checker
    import slice_data_pkg::*;
(
    input logic             clk_adder,
    input logic             rstb,
    input logic             sign,
    input logic             en_tdc_phase_reverse,
    input logic [n_adc-1:0] adder_out,
    input logic             sign_out,
    input logic             clk_tdc_phase_reverse
);

    int assert_failures = 0;  // Count of failed assertions.

    // Two synchronizer flops sit between the enable pin and the chain.
    property p_reverse_sync;
        @(posedge clk_adder) disable iff (!rstb)
            $past(rstb, 2) |-> clk_tdc_phase_reverse == $past(en_tdc_phase_reverse, 2);
    endproperty

    property p_sign_latency;
        @(posedge clk_adder) disable iff (!rstb)
            $past(rstb, pipe_depth) |-> sign_out == $past(sign, pipe_depth);
    endproperty

    property p_reset_outputs;
        @(posedge clk_adder) (!rstb ##1 !rstb) |-> (adder_out == '0 && !sign_out);
    endproperty

    a_reverse_sync: assert property (p_reverse_sync) else begin
        assert_failures++;
        $error("clk_tdc_phase_reverse does not follow the enable two edges later");
    end

    a_sign_latency: assert property (p_sign_latency) else begin
        assert_failures++;
        $error("sign_out does not follow sign three edges later");
    end

    a_reset_outputs: assert property (p_reset_outputs) else begin
        assert_failures++;
        $error("adder_out or sign_out is not zero during reset");
    end

endmodule

`default_nettype wire

//--- verification/tb_stochastic_adc_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stochastic_adc_backend
    import slice_data_pkg::*;
    import slice_ctl_pkg::*;
();

    typedef enum int {pat_zero, pat_ones, pat_thermo, pat_single, pat_random} pat_kind_t;

    logic               clk_adder;
    logic               rstb;
    logic [n_chain-1:0] ff_out;
    logic               sign;
    logic               en_tdc_phase_reverse;
    logic [n_ctl-1:0]   ctl_v2t_p;
    logic [n_ctl-1:0]   ctl_v2t_n;
    logic [n_ctl-1:0]   ctl_dcdl;
    logic [n_adc-1:0]   adder_out;
    logic               sign_out;
    logic               clk_tdc_phase_reverse;
    logic [n_thm-1:0]   thm_ctl_v2t_p;
    logic [n_thm-1:0]   thm_ctl_v2t_n;
    logic [n_thm-1:0]   thm_ctl_dcdl;

    // Stimulus table with one entry per row in each queue.
    string            row_name [$];
    pat_kind_t        row_kind [$];
    int               row_arg [$];
    logic             row_sign [$];
    logic             row_rev [$];
    logic [n_ctl-1:0] row_ctl_p [$];
    logic [n_ctl-1:0] row_ctl_n [$];
    logic [n_ctl-1:0] row_ctl_d [$];
    int               row_reps [$];

    // Samples in flight through the pipeline.
    int               exp_mag_q [$];
    logic             exp_sign_q [$];
    bit               exp_chk_q [$];
    string            exp_name_q [$];
    logic             rev_q [$];

    logic [31:0]      lfsr_state;
    int               checks = 0;
    int               errors = 0;
    int               watchdog_cycles = 0;
    bit               table_ready = 1'b0;

    stochastic_adc_backend dut (
        .clk_adder(clk_adder),
        .rstb(rstb),
        .ff_out(ff_out),
        .sign(sign),
        .en_tdc_phase_reverse(en_tdc_phase_reverse),
        .ctl_v2t_p(ctl_v2t_p),
        .ctl_v2t_n(ctl_v2t_n),
        .ctl_dcdl(ctl_dcdl),
        .adder_out(adder_out),
        .sign_out(sign_out),
        .clk_tdc_phase_reverse(clk_tdc_phase_reverse),
        .thm_ctl_v2t_p(thm_ctl_v2t_p),
        .thm_ctl_v2t_n(thm_ctl_v2t_n),
        .thm_ctl_dcdl(thm_ctl_dcdl)
    );

    bind stochastic_adc_backend stochastic_adc_backend_checker icheck (
        .clk_adder(clk_adder),
        .rstb(rstb),
        .sign(sign),
        .en_tdc_phase_reverse(en_tdc_phase_reverse),
        .adder_out(adder_out),
        .sign_out(sign_out),
        .clk_tdc_phase_reverse(clk_tdc_phase_reverse)
    );

    initial clk_adder = 1'b0;
    always #2 clk_adder = ~clk_adder;  // 4 ns period.

    task automatic add_row(input string name, input pat_kind_t kind, input int arg,
                           input logic s, input logic rev, input logic [n_ctl-1:0] cp,
                           input logic [n_ctl-1:0] cn, input logic [n_ctl-1:0] cd,
                           input int reps);
        row_name.push_back(name);
        row_kind.push_back(kind);
        row_arg.push_back(arg);
        row_sign.push_back(s);
        row_rev.push_back(rev);
        row_ctl_p.push_back(cp);
        row_ctl_n.push_back(cn);
        row_ctl_d.push_back(cd);
        row_reps.push_back(reps);
    endtask

    task automatic build_table();
        add_row("all_zero",       pat_zero,   0,   1'b0, 1'b0, 0,  0,  0,  2);
        add_row("all_ones",       pat_ones,   0,   1'b1, 1'b0, 1,  1,  1,  2);
        add_row("thermo_1",       pat_thermo, 1,   1'b0, 1'b0, 17, 17, 17, 1);
        add_row("thermo_100",     pat_thermo, 100, 1'b1, 1'b0, 31, 31, 31, 1);
        add_row("thermo_254",     pat_thermo, 254, 1'b0, 1'b0, 17, 1,  0,  1);
        add_row("single_0",       pat_single, 0,   1'b1, 1'b0, 0,  31, 1,  1);
        add_row("single_127",     pat_single, 127, 1'b0, 1'b0, 31, 0,  17, 1);
        add_row("single_254",     pat_single, 254, 1'b1, 1'b0, 1,  17, 31, 1);
        add_row("rand_pos_a",     pat_random, 0,   1'b0, 1'b0, 5,  9,  3,  1);
        add_row("rand_neg_a",     pat_random, 0,   1'b1, 1'b0, 6,  10, 4,  1);
        add_row("rand_pos_b",     pat_random, 0,   1'b0, 1'b0, 7,  11, 5,  1);
        add_row("rand_neg_b",     pat_random, 0,   1'b1, 1'b0, 8,  12, 6,  1);
        add_row("rand_burst",     pat_random, 0,   1'b0, 1'b0, 16, 16, 16, 24);
        add_row("rev_all_zero",   pat_zero,   0,   1'b1, 1'b1, 2,  3,  4,  2);
        add_row("rev_thermo_40",  pat_thermo, 40,  1'b0, 1'b1, 20, 21, 22, 1);
        add_row("rev_single_200", pat_single, 200, 1'b1, 1'b1, 30, 29, 28, 1);
        add_row("rev_random",     pat_random, 0,   1'b0, 1'b1, 13, 14, 15, 8);
        add_row("fwd_all_ones",   pat_ones,   0,   1'b1, 1'b0, 0,  0,  0,  2);
        add_row("fwd_random",     pat_random, 0,   1'b1, 1'b0, 25, 26, 27, 4);
    endtask

    // Fibonacci LFSR with taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int count_ones(input logic [n_chain-1:0] pat);
        int cnt;
        cnt = 0;
        for (int i = 0; i < n_chain; i++) begin
            if (pat[i]) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    // Code k turns on the k lowest cells.
    function automatic logic [n_thm-1:0] thermo_code(input logic [n_ctl-1:0] code);
        logic [31:0] full;
        full = (32'd1 << code) - 32'd1;
        return full[n_thm-1:0];
    endfunction

    task automatic make_pattern(input pat_kind_t kind, input int arg,
                                output logic [n_chain-1:0] pat);
        pat = '0;
        case (kind)
            pat_ones: pat = '1;
            pat_thermo: begin
                for (int i = 0; i < arg; i++) begin
                    pat[i] = 1'b1;
                end
            end
            pat_single: pat[arg] = 1'b1;
            pat_random: begin
                for (int i = 0; i < n_chain; i++) begin
                    lfsr_state = lfsr_step(lfsr_state);  // One step per bit.
                    pat[i] = lfsr_state[0];
                end
            end
            default: pat = '0;
        endcase
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch: %s expected 0x%0h actual 0x%0h", what, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        int    mag;
        logic  s;
        bit    chk;
        string name;
        if (rev_q.size() >= 2) begin  // Two synchronizer flops.
            check_value("clk_tdc_phase_reverse", rev_q.pop_front(), clk_tdc_phase_reverse);
        end
        if (exp_mag_q.size() >= pipe_depth) begin
            mag = exp_mag_q.pop_front();
            s = exp_sign_q.pop_front();
            chk = exp_chk_q.pop_front();
            name = exp_name_q.pop_front();
            if (chk) begin
                check_value({name, " adder_out"}, mag, adder_out);
                check_value({name, " sign_out"}, s, sign_out);
            end
        end
    endtask

    task automatic step_cycle(input string name, input logic [n_chain-1:0] pat,
                              input logic s, input logic rev, input logic [n_ctl-1:0] cp,
                              input logic [n_ctl-1:0] cn, input logic [n_ctl-1:0] cd,
                              input bit checked);
        int cnt;
        @(posedge clk_adder);
        #0.5;
        compare_outputs();
        ff_out = pat;
        sign = s;
        en_tdc_phase_reverse = rev;
        ctl_v2t_p = cp;
        ctl_v2t_n = cn;
        ctl_dcdl = cd;
        cnt = count_ones(pat);
        exp_mag_q.push_back(rev ? n_chain - cnt : cnt);  // Reversed chain counts zeros.
        exp_sign_q.push_back(s);
        exp_chk_q.push_back(checked);
        exp_name_q.push_back(name);
        rev_q.push_back(rev);
        #0.5;
        check_value({name, " thm_ctl_v2t_p"}, thermo_code(cp), thm_ctl_v2t_p);
        check_value({name, " thm_ctl_v2t_n"}, thermo_code(cn), thm_ctl_v2t_n);
        check_value({name, " thm_ctl_dcdl"}, thermo_code(cd), thm_ctl_dcdl);
    endtask

    initial begin
        logic [n_chain-1:0] pat;
        logic               cur_rev;
        int                 total;
        rstb = 1'b0;
        ff_out = '0;
        sign = 1'b0;
        en_tdc_phase_reverse = 1'b0;
        ctl_v2t_p = '0;
        ctl_v2t_n = '0;
        ctl_dcdl = '0;
        lfsr_state = 32'h3d6b_22c7;
        build_table();
        total = 5 + 2 + pipe_depth + 50;  // Reset, idle, drain and margin.
        for (int r = 0; r < row_name.size(); r++) begin
            total += row_reps[r] + 2;
        end
        watchdog_cycles = total;
        table_ready = 1'b1;

        repeat (5) @(posedge clk_adder);
        #0.5;
        check_value("reset adder_out", 0, adder_out);
        check_value("reset sign_out", 0, sign_out);
        rstb = 1'b1;
        @(posedge clk_adder);
        #0.5;
        check_value("after reset adder_out", 0, adder_out);
        check_value("after reset sign_out", 0, sign_out);
        check_value("after reset clk_tdc_phase_reverse", 0, clk_tdc_phase_reverse);

        cur_rev = 1'b0;
        for (int r = 0; r < row_name.size(); r++) begin
            if (row_rev[r] != cur_rev) begin
                repeat (2) step_cycle("settle", '0, 1'b0, row_rev[r], row_ctl_p[r],
                                      row_ctl_n[r], row_ctl_d[r], 1'b0);
                cur_rev = row_rev[r];
            end
            for (int k = 0; k < row_reps[r]; k++) begin
                make_pattern(row_kind[r], row_arg[r], pat);
                step_cycle(row_name[r], pat, row_sign[r], row_rev[r], row_ctl_p[r],
                           row_ctl_n[r], row_ctl_d[r], 1'b1);
            end
        end
        repeat (pipe_depth) step_cycle("drain", '0, 1'b0, cur_rev, '0, '0, '0, 1'b0);

        $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, dut.icheck.assert_failures);
        if (errors == 0 && dut.icheck.assert_failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(watchdog_cycles * 4);
        $display("error: the run timed out after %0d clock cycles", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
verilog/slice_data_pkg.sv
verilog/slice_ctl_pkg.sv
verilog/bin2thm.sv
verilog/tdc_capture.sv
verilog/wallace_adder.sv
verilog/stochastic_adc_backend.sv
verification/stochastic_adc_backend_checker.sv
verification/tb_stochastic_adc_backend.sv
